// ==== logic/cia_bus_decode.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Processor bus front end. Builds read and write strobes from
// phi2_n, cs_n and rw, passes address and data to the blocks,
// and registers the selected read value onto db_out.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module cia_bus_decode import cia_regmap_pkg::*; (
  input  logic                 clk,
  input  logic                 int_reset,
  input  logic                 phi2_n,
  input  logic                 cs_n,
  input  logic                 rw,
  input  logic [3:0]           rs,
  input  logic [bus_width-1:0] db_in,
  cia_reg_bus_if.driver        bus,
  input  logic [bus_width-1:0] port_rdata,
  input  logic [bus_width-1:0] timer_rdata,
  input  logic [bus_width-1:0] icr_rdata,
  output logic [bus_width-1:0] db_out
);

  cia_reg_e             addr;
  logic                 rd;
  logic [bus_width-1:0] rdata;

  assign addr = cia_reg_e'(rs);
  assign rd   = phi2_n & ~cs_n & rw;

  assign bus.rd    = rd;
  assign bus.wr    = phi2_n & ~cs_n & ~rw;
  assign bus.rs    = addr;
  assign bus.wdata = db_in;

  // Read value by register group
  always_comb begin
    rdata = '0;
    case (addr)
      reg_pra, reg_prb, reg_ddra, reg_ddrb:
        rdata = port_rdata;
      reg_ta_lo, reg_ta_hi, reg_tb_lo, reg_tb_hi:
        rdata = timer_rdata;
      reg_cra, reg_crb:
        rdata = timer_rdata & ctrl_read_mask;
      reg_icr:
        rdata = icr_rdata;
      // TOD and serial port are not implemented
      reg_tod_10ths, reg_tod_sec, reg_tod_min, reg_tod_hr, reg_sdr:
        rdata = '0;
      default:
        rdata = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (int_reset) begin
      db_out <= '0;
    end else if (rd) begin
      db_out <= rdata;
    end
  end

endmodule

// ==== logic/cia_irq.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Interrupt control. Sticky source flags, the mask register
// with set/clear writes, irq_n and clear-on-read of the ICR.
// mode high selects the newer part with per-clk mask updates.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module cia_irq import cia_regmap_pkg::*, cia_timer_pkg::*; (
  input  logic                 clk,
  input  logic                 int_reset,
  input  logic                 mode,
  input  logic                 phi2_p,
  cia_reg_bus_if.receiver      bus,
  input  logic                 ta_underflow,
  input  logic                 tb_underflow,
  input  logic                 flag_event,
  output logic                 irq_n,
  output logic [bus_width-1:0] icr_rdata
);

  logic [icr_width-1:0] imr;
  logic [icr_width-1:0] icr_flags;
  logic [icr_width-1:0] mask_sel;
  logic                 mask_set;
  logic                 icr_clear;

  always_ff @(posedge clk) begin
    if (int_reset) begin
      imr       <= '0;
      icr_flags <= '0;
      mask_sel  <= '0;
      mask_set  <= 1'b0;
      icr_clear <= 1'b0;
      irq_n     <= 1'b1;
    end else begin
      if (bus.wr && bus.rs == reg_icr) begin
        mask_set <= bus.wdata[bus_width-1];
        mask_sel <= bus.wdata[icr_width-1:0];
      end
      if (bus.rd && bus.rs == reg_icr) icr_clear <= 1'b1;

      if (phi2_p | mode) begin
        imr <= mask_set ? imr | mask_sel : imr & ~mask_sel;
        if (irq_n) irq_n <= ~|(imr & icr_flags);
      end
      if (phi2_p & icr_clear) begin
        icr_flags <= '0;
        irq_n     <= 1'b1;
        icr_clear <= 1'b0;
      end

      // New events win over a clear in the same clk
      if (ta_underflow) icr_flags[src_ta]   <= 1'b1;
      if (tb_underflow) icr_flags[src_tb]   <= 1'b1;
      if (flag_event)   icr_flags[src_flag] <= 1'b1;
      // No TOD alarm or serial port in this core
      icr_flags[src_alarm] <= 1'b0;
      icr_flags[src_sp]    <= 1'b0;
    end
  end

  assign icr_rdata = {~irq_n, {(bus_width - 1 - icr_width){1'b0}}, icr_flags};

endmodule

// ==== logic/cia_ports.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Parallel ports A and B with their direction registers, the
// PB6/PB7 timer override, FLAG edge detection and the pc_n
// handshake pulse on port B accesses.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module cia_ports import cia_regmap_pkg::*; (
  input  logic                 clk,
  input  logic                 int_reset,
  input  logic                 phi2_p,
  input  logic                 cs_n,
  cia_reg_bus_if.receiver      bus,
  input  logic [bus_width-1:0] pa_in,
  input  logic [bus_width-1:0] pb_in,
  input  logic                 pb6_timer,
  input  logic                 pb6_en,
  input  logic                 pb7_timer,
  input  logic                 pb7_en,
  input  logic                 flag_n,
  output logic [bus_width-1:0] pa_out,
  output logic [bus_width-1:0] pb_out,
  output logic                 pc_n,
  output logic                 flag_event,
  output logic [bus_width-1:0] port_rdata
);

  logic [bus_width-1:0] pra;
  logic [bus_width-1:0] prb;
  logic [bus_width-1:0] ddra;
  logic [bus_width-1:0] ddrb;
  logic [bus_width-1:0] pb_drive;
  logic                 flag_prev;

  always_ff @(posedge clk) begin
    if (int_reset) begin
      pra  <= '0;
      prb  <= '0;
      ddra <= '0;
      ddrb <= '0;
    end else if (bus.wr) begin
      case (bus.rs)
        reg_pra:  pra  <= bus.wdata;
        reg_prb:  prb  <= bus.wdata;
        reg_ddra: ddra <= bus.wdata;
        reg_ddrb: ddrb <= bus.wdata;
        default: ;
      endcase
    end
  end

  // Input bits float high
  always_comb begin
    pb_drive    = prb | ~ddrb;
    if (pb6_en) pb_drive[6] = pb6_timer;
    if (pb7_en) pb_drive[7] = pb7_timer;
  end

  always_ff @(posedge clk) begin
    if (int_reset) begin
      pa_out    <= '0;
      pb_out    <= '0;
      pc_n      <= 1'b1;
      flag_prev <= 1'b1;
    end else begin
      if (phi2_p) begin
        pa_out    <= pra | ~ddra;
        pb_out    <= pb_drive;
        flag_prev <= flag_n;
      end
      // Low from the PRB access until the next phi2 rise
      if (!cs_n && bus.rs == reg_prb) begin
        pc_n <= 1'b0;
      end else if (phi2_p) begin
        pc_n <= 1'b1;
      end
    end
  end

  assign flag_event = phi2_p & flag_prev & ~flag_n;

  always_comb begin
    case (bus.rs)
      reg_pra:  port_rdata = pa_in;
      reg_prb:  port_rdata = pb_in;
      reg_ddra: port_rdata = ddra;
      reg_ddrb: port_rdata = ddrb;
      default:  port_rdata = '0;
    endcase
  end

endmodule

// ==== logic/cia_reg_bus_if.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Internal register bus. The decoder drives the strobes, the
// register address and the write data; each function block
// receives them and decodes its own registers.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

interface cia_reg_bus_if import cia_regmap_pkg::*; ();

  logic                 rd;
  logic                 wr;
  cia_reg_e             rs;
  logic [bus_width-1:0] wdata;

  modport driver (
    output rd,
    output wr,
    output rs,
    output wdata
  );

  modport receiver (
    input rd,
    input wr,
    input rs,
    input wdata
  );

endinterface

// ==== logic/cia_regmap_pkg.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Register map of the CIA core: the sixteen register addresses,
// the data bus width and the read-back mask of CRA and CRB.
// Imported by the decoder, the function blocks and the top level.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package cia_regmap_pkg;

  localparam int bus_width = 8;

  // Force-load is a strobe and always reads as zero
  localparam logic [bus_width-1:0] ctrl_read_mask = 8'hef;

  typedef enum logic [3:0] {
    reg_pra       = 4'h0,
    reg_prb       = 4'h1,
    reg_ddra      = 4'h2,
    reg_ddrb      = 4'h3,
    reg_ta_lo     = 4'h4,
    reg_ta_hi     = 4'h5,
    reg_tb_lo     = 4'h6,
    reg_tb_hi     = 4'h7,
    reg_tod_10ths = 4'h8,
    reg_tod_sec   = 4'h9,
    reg_tod_min   = 4'ha,
    reg_tod_hr    = 4'hb,
    reg_sdr       = 4'hc,
    reg_icr       = 4'hd,
    reg_cra       = 4'he,
    reg_crb       = 4'hf
  } cia_reg_e;

endpackage

// ==== logic/cia_timer_pkg.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Timer and interrupt definitions: control register bit
// positions, timer width and the interrupt source numbering.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package cia_timer_pkg;

  localparam int timer_width = 16;
  localparam int icr_width   = 5;

  // CRA / CRB bit positions
  localparam int cr_start      = 0;
  localparam int cr_pbon       = 1;
  localparam int cr_toggle     = 2;
  localparam int cr_oneshot    = 3;
  localparam int cr_load       = 4;
  localparam int cra_inmode    = 5;
  localparam int crb_inmode_lo = 5;
  localparam int crb_inmode_hi = 6;

  // Bit index of each source in the ICR
  typedef enum logic [2:0] {
    src_ta    = 3'd0,
    src_tb    = 3'd1,
    src_alarm = 3'd2,
    src_sp    = 3'd3,
    src_flag  = 3'd4
  } irq_src_e;

endpackage

// ==== logic/cia_timers.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Timers A and B. Each has a 16-bit latch, a down counter, a
// control register and a two-stage count pipeline clocked by
// phi2_p. Underflows feed the ICR, timer B and PB6/PB7.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module cia_timers import cia_regmap_pkg::*, cia_timer_pkg::*; (
  input  logic                 clk,
  input  logic                 int_reset,
  input  logic                 phi2_p,
  input  logic                 cnt_in,
  cia_reg_bus_if.receiver      bus,
  output logic                 ta_underflow,
  output logic                 tb_underflow,
  output logic                 pb6_timer,
  output logic                 pb6_en,
  output logic                 pb7_timer,
  output logic                 pb7_en,
  output logic [bus_width-1:0] timer_rdata
);

  logic                              cnt_prev;
  logic                              count0;
  logic                              count1;
  logic [1:0]                        uf_raw;
  logic [1:0]                        ff_q;
  logic [1:0][timer_width-1:0]       cur;
  logic [1:0][bus_width-1:0]         ctrl;

  // CNT rising edge delayed by two phi2 stages
  always_ff @(posedge clk) begin
    if (int_reset) begin
      cnt_prev <= 1'b0;
      count0   <= 1'b0;
      count1   <= 1'b0;
    end else if (phi2_p) begin
      cnt_prev <= cnt_in;
      count0   <= cnt_in & ~cnt_prev;
      count1   <= count0;
    end
  end

  for (genvar i = 0; i < 2; i++) begin : g_tmr
    localparam cia_reg_e lo_addr = (i == 0) ? reg_ta_lo : reg_tb_lo;
    localparam cia_reg_e hi_addr = (i == 0) ? reg_ta_hi : reg_tb_hi;
    localparam cia_reg_e cr_addr = (i == 0) ? reg_cra : reg_crb;

    logic [bus_width-1:0]   cr;
    logic [timer_width-1:0] latch;
    logic [timer_width-1:0] count;
    logic [timer_width-1:0] next_val;
    logic                   tin;
    logic                   cnt2;
    logic                   cnt3;
    logic                   load1;
    logic                   oneshot0;
    logic                   ff;

    // Timer B may count A underflows, optionally gated by CNT
    if (i == 0) begin : g_src_a
      assign tin = cr[cra_inmode] ? count1 : 1'b1;
    end else begin : g_src_b
      assign tin = cr[crb_inmode_hi] ? (uf_raw[0] & (~cr[crb_inmode_lo] | cnt_in))
                                     : (~cr[crb_inmode_lo] | count1);
    end

    assign next_val  = cnt3 ? count - 1'b1 : count;
    assign uf_raw[i] = (next_val == '0) & cnt2;
    assign ff_q[i]   = ff;
    assign cur[i]    = count;
    assign ctrl[i]   = cr;

    always_ff @(posedge clk) begin
      if (int_reset) begin
        cr       <= '0;
        latch    <= '1;
        count    <= '0;
        cnt2     <= 1'b0;
        cnt3     <= 1'b0;
        load1    <= 1'b0;
        oneshot0 <= 1'b0;
        ff       <= 1'b0;
      end else begin
        if (phi2_p) begin
          cnt2        <= tin & cr[cr_start];
          cnt3        <= cnt2;
          load1       <= cr[cr_load];
          cr[cr_load] <= 1'b0;
          oneshot0    <= cr[cr_oneshot];
          count       <= next_val;
          if (uf_raw[i]) begin
            ff    <= ~ff;
            count <= latch;
            cnt3  <= 1'b0;
            if (cr[cr_oneshot] | oneshot0) begin
              cr[cr_start] <= 1'b0;
              cnt2         <= 1'b0;
            end
          end
          // Force load one phi2 after the CR write
          if (load1) begin
            count <= latch;
            cnt3  <= 1'b0;
          end
        end
        if (bus.wr) begin
          if (bus.rs == lo_addr) begin
            latch[7:0] <= bus.wdata;
            if (uf_raw[i]) count <= {latch[15:8], bus.wdata};
          end else if (bus.rs == hi_addr) begin
            latch[15:8] <= bus.wdata;
            // A stopped timer loads on a high-byte write
            if (!cr[cr_start]) begin
              count <= {bus.wdata, latch[7:0]};
              cnt3  <= 1'b0;
            end
          end else if (bus.rs == cr_addr) begin
            cr <= bus.wdata;
            ff <= ff | (bus.wdata[cr_start] & ~cr[cr_start]);
          end
        end
      end
    end
  end

  assign ta_underflow = phi2_p & uf_raw[0];
  assign tb_underflow = phi2_p & uf_raw[1];

  assign pb6_en    = ctrl[0][cr_pbon];
  assign pb7_en    = ctrl[1][cr_pbon];
  assign pb6_timer = ctrl[0][cr_toggle] ? ff_q[0] ^ ta_underflow : ta_underflow;
  assign pb7_timer = ctrl[1][cr_toggle] ? ff_q[1] ^ tb_underflow : tb_underflow;

  always_comb begin
    case (bus.rs)
      reg_ta_lo: timer_rdata = cur[0][7:0];
      reg_ta_hi: timer_rdata = cur[0][15:8];
      reg_tb_lo: timer_rdata = cur[1][7:0];
      reg_tb_hi: timer_rdata = cur[1][15:8];
      reg_cra:   timer_rdata = ctrl[0];
      reg_crb:   timer_rdata = ctrl[1];
      default:   timer_rdata = '0;
    endcase
  end

endmodule

// ==== logic/cia_top.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// CIA core top level. Joins the bus decoder, ports, timers and
// interrupt block; all chip pins are plain ports.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module cia_top import cia_regmap_pkg::*; (
  input  logic                 clk,
  input  logic                 int_reset,
  input  logic                 mode,
  input  logic                 phi2_p,
  input  logic                 phi2_n,
  input  logic                 cs_n,
  input  logic                 rw,
  input  logic [3:0]           rs,
  input  logic [bus_width-1:0] db_in,
  output logic [bus_width-1:0] db_out,
  input  logic [bus_width-1:0] pa_in,
  output logic [bus_width-1:0] pa_out,
  input  logic [bus_width-1:0] pb_in,
  output logic [bus_width-1:0] pb_out,
  input  logic                 flag_n,
  output logic                 pc_n,
  input  logic                 cnt_in,
  output logic                 irq_n
);

  logic [bus_width-1:0] port_rdata;
  logic [bus_width-1:0] timer_rdata;
  logic [bus_width-1:0] icr_rdata;
  logic                 ta_underflow;
  logic                 tb_underflow;
  logic                 flag_event;
  logic                 pb6_timer;
  logic                 pb6_en;
  logic                 pb7_timer;
  logic                 pb7_en;

  cia_reg_bus_if bus ();

  cia_bus_decode u_decode (
    .clk         (clk),
    .int_reset   (int_reset),
    .phi2_n      (phi2_n),
    .cs_n        (cs_n),
    .rw          (rw),
    .rs          (rs),
    .db_in       (db_in),
    .bus         (bus.driver),
    .port_rdata  (port_rdata),
    .timer_rdata (timer_rdata),
    .icr_rdata   (icr_rdata),
    .db_out      (db_out)
  );

  cia_ports u_ports (
    .clk        (clk),
    .int_reset  (int_reset),
    .phi2_p     (phi2_p),
    .cs_n       (cs_n),
    .bus        (bus.receiver),
    .pa_in      (pa_in),
    .pb_in      (pb_in),
    .pb6_timer  (pb6_timer),
    .pb6_en     (pb6_en),
    .pb7_timer  (pb7_timer),
    .pb7_en     (pb7_en),
    .flag_n     (flag_n),
    .pa_out     (pa_out),
    .pb_out     (pb_out),
    .pc_n       (pc_n),
    .flag_event (flag_event),
    .port_rdata (port_rdata)
  );

  cia_timers u_timers (
    .clk          (clk),
    .int_reset    (int_reset),
    .phi2_p       (phi2_p),
    .cnt_in       (cnt_in),
    .bus          (bus.receiver),
    .ta_underflow (ta_underflow),
    .tb_underflow (tb_underflow),
    .pb6_timer    (pb6_timer),
    .pb6_en       (pb6_en),
    .pb7_timer    (pb7_timer),
    .pb7_en       (pb7_en),
    .timer_rdata  (timer_rdata)
  );

  cia_irq u_irq (
    .clk          (clk),
    .int_reset    (int_reset),
    .mode         (mode),
    .phi2_p       (phi2_p),
    .bus          (bus.receiver),
    .ta_underflow (ta_underflow),
    .tb_underflow (tb_underflow),
    .flag_event   (flag_event),
    .irq_n        (irq_n),
    .icr_rdata    (icr_rdata)
  );

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the CIA testbench with Verilator.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f sources.f --top-module cia_tb -o cia_sim
./obj_dir/cia_sim > sim.log
cat sim.log

if grep -q "Test failed" sim.log; then
  exit 1
fi
exit 0

// ==== sim/cia_tb.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench for the CIA core. Drives the processor bus in step
// with phi2, runs port, timer, chaining and interrupt tests and
// checks results against reference functions.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module cia_tb import cia_regmap_pkg::*; ();

  localparam int la_oneshot = 10;
  localparam int la_cont    = 6;
  localparam int la_chain   = 4;
  localparam int nb_chain   = 3;
  localparam int la_mask    = 5;
  localparam int bus_ops    = 64;
  // Four clk per phi2 and at most eight clk per bus cycle
  localparam int timeout_cycles = 4 * (la_oneshot + 10 * (la_cont + 1)
      + (nb_chain + 3) * (la_chain + 1) + la_mask + 60) + 8 * bus_ops + 200;

  logic       clk;
  logic       int_reset;
  logic       mode;
  logic       phi2_p = 1'b0;
  logic       phi2_n = 1'b0;
  logic       cs_n;
  logic       rw;
  logic [3:0] rs;
  logic [7:0] db_in;
  logic [7:0] db_out;
  logic [7:0] pa_in;
  logic [7:0] pa_out;
  logic [7:0] pb_in;
  logic [7:0] pb_out;
  logic       flag_n;
  logic       pc_n;
  logic       cnt_in;
  logic       irq_n;

  logic [1:0]  ph = 2'd0;
  logic [31:0] lcg_state;
  int          cycle_count = 0;
  int          errors = 0;
  int          checks = 0;
  int          event_errors = 0;
  int          err_start;
  string       name_q[$];
  logic [7:0]  exp_q[$];
  logic [7:0]  got_q[$];

  cia_top UUT (
    .clk       (clk),
    .int_reset (int_reset),
    .mode      (mode),
    .phi2_p    (phi2_p),
    .phi2_n    (phi2_n),
    .cs_n      (cs_n),
    .rw        (rw),
    .rs        (rs),
    .db_in     (db_in),
    .db_out    (db_out),
    .pa_in     (pa_in),
    .pa_out    (pa_out),
    .pb_in     (pb_in),
    .pb_out    (pb_out),
    .flag_n    (flag_n),
    .pc_n      (pc_n),
    .cnt_in    (cnt_in),
    .irq_n     (irq_n)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // phi2_n trails phi2_p by two clk
  always @(posedge clk) begin
    ph     <= ph + 2'd1;
    phi2_p <= (ph == 2'd3);
    phi2_n <= (ph == 2'd1);
  end

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= timeout_cycles) begin
      $display("Timeout: run exceeded %0d clk cycles", timeout_cycles);
      $display("Test failed");
      $finish;
    end
  end

  function automatic logic [31:0] lcg_step(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic logic [7:0] port_ref(input logic [7:0] data, input logic [7:0] ddr);
    return data | ~ddr;
  endfunction

  function automatic logic [7:0] icr_ref(input logic [4:0] flags, input logic irq);
    return {irq, 2'b00, flags};
  endfunction

  // Force load reads back as zero
  function automatic logic [7:0] ctrl_read_ref(input logic [7:0] cr);
    return cr & ~8'h10;
  endfunction

  function automatic int period_ref(input int latch);
    return latch + 1;
  endfunction

  task automatic get_byte(output logic [7:0] b);
    lcg_state = lcg_step(lcg_state);
    b = lcg_state[23:16];
  endtask

  task automatic expect_eq(input string name, input logic [7:0] exp, input logic [7:0] got);
    name_q.push_back(name);
    exp_q.push_back(exp);
    got_q.push_back(got);
  endtask

  // Drains the queued checks on the falling edge
  always @(negedge clk) begin : compare
    while (checks < got_q.size()) begin
      assert (got_q[checks] == exp_q[checks]) else begin
        $display("[ERROR] %0t %s expected 'h%02h got 'h%02h",
                 $time, name_q[checks], exp_q[checks], got_q[checks]);
        errors++;
      end
      checks++;
    end
  end

  task automatic bus_cycle(input logic read, input logic [3:0] addr, input logic [7:0] data);
    @(posedge clk);
    cs_n  <= 1'b0;
    rw    <= read;
    rs    <= addr;
    db_in <= data;
    @(posedge clk);
    while (phi2_n !== 1'b1) @(posedge clk);
    cs_n <= 1'b1;
    rw   <= 1'b1;
  endtask

  task automatic write_reg(input cia_reg_e addr, input logic [7:0] data);
    bus_cycle(1'b0, addr, data);
  endtask

  task automatic read_reg(input cia_reg_e addr, output logic [7:0] data);
    bus_cycle(1'b1, addr, 8'h00);
    @(negedge clk);
    data = db_out;
  endtask

  task automatic next_phi2();
    @(posedge clk);
    while (phi2_p !== 1'b1) @(posedge clk);
    @(negedge clk);
  endtask

  task automatic finish_test(input string name);
    repeat (2) @(posedge clk);
    $display("%-24s errors %0d", name, errors + event_errors - err_start);
  endtask

  task automatic check_ports();
    logic [7:0] pra;
    logic [7:0] ddra;
    logic [7:0] prb;
    logic [7:0] ddrb;
    logic [7:0] rd;
    err_start = errors + event_errors;
    for (int i = 0; i < 4; i++) begin
      get_byte(pra);
      get_byte(ddra);
      get_byte(prb);
      get_byte(ddrb);
      write_reg(reg_pra, pra);
      write_reg(reg_ddra, ddra);
      write_reg(reg_prb, prb);
      // pc_n stays low after a PRB access until the next phi2
      @(negedge clk);
      expect_eq("pc_n", 8'h00, 8'(pc_n));
      write_reg(reg_ddrb, ddrb);
      next_phi2();
      expect_eq("pa_out", port_ref(pra, ddra), pa_out);
      expect_eq("pb_out", port_ref(prb, ddrb), pb_out);
      expect_eq("pc_n", 8'h01, 8'(pc_n));
      read_reg(reg_ddra, rd);
      expect_eq("ddra", ddra, rd);
      read_reg(reg_ddrb, rd);
      expect_eq("ddrb", ddrb, rd);
    end
    finish_test("port writes");
  endtask

  task automatic oneshot_irq();
    logic [7:0] rd;
    int         n;
    logic       fell;
    err_start = errors + event_errors;
    write_reg(reg_icr, 8'h81);
    write_reg(reg_ta_lo, 8'(la_oneshot));
    write_reg(reg_ta_hi, 8'(la_oneshot >> 8));
    // Start in one-shot mode
    write_reg(reg_cra, 8'h09);
    n = 0;
    fell = 1'b0;
    while (!fell && n < la_oneshot + 4) begin
      next_phi2();
      n++;
      fell = !irq_n;
    end
    assert (fell) else begin
      $display("irq_n did not fall within %0d phi2 pulses of the timer A start",
               la_oneshot + 4);
      event_errors++;
    end
    read_reg(reg_icr, rd);
    expect_eq("icr", icr_ref(5'b00001, 1'b1), rd);
    next_phi2();
    next_phi2();
    expect_eq("irq_n", 8'h01, 8'(irq_n));
    read_reg(reg_cra, rd);
    expect_eq("cra", ctrl_read_ref(8'h09 & 8'hfe), rd);
    finish_test("timer A one-shot");
  endtask

  task automatic continuous_pb6();
    logic prev;
    int   since;
    int   toggles;
    int   total;
    err_start = errors + event_errors;
    write_reg(reg_icr, 8'h1f);
    write_reg(reg_ta_lo, 8'(la_cont));
    write_reg(reg_ta_hi, 8'(la_cont >> 8));
    // Start with PB6 in toggle mode
    write_reg(reg_cra, 8'h07);
    next_phi2();
    prev = pb_out[6];
    since = 0;
    toggles = 0;
    total = 0;
    while (toggles < 9 && total < 10 * (la_cont + 1) + 10) begin
      next_phi2();
      since++;
      total++;
      if (pb_out[6] != prev) begin
        // First underflow carries the start latency
        if (toggles > 0) expect_eq("pb6 interval", 8'(period_ref(la_cont)), 8'(since));
        toggles++;
        since = 0;
        prev = pb_out[6];
      end
    end
    assert (toggles == 9) else begin
      $display("PB6 toggled only %0d times in %0d phi2 pulses", toggles, total);
      event_errors++;
    end
    write_reg(reg_cra, 8'h00);
    finish_test("timer A continuous PB6");
  endtask

  task automatic chained_tb();
    logic [7:0] rd;
    logic       prev;
    int         toggles;
    int         total;
    logic       fell;
    err_start = errors + event_errors;
    read_reg(reg_icr, rd);
    write_reg(reg_icr, 8'h82);
    write_reg(reg_ta_lo, 8'(la_chain));
    write_reg(reg_ta_hi, 8'(la_chain >> 8));
    write_reg(reg_tb_lo, 8'(nb_chain));
    write_reg(reg_tb_hi, 8'(nb_chain >> 8));
    // Timer B started on A underflows
    write_reg(reg_crb, 8'h41);
    write_reg(reg_cra, 8'h07);
    next_phi2();
    prev = pb_out[6];
    toggles = 0;
    total = 0;
    fell = 1'b0;
    while (!fell && total < (nb_chain + 3) * (la_chain + 1) + 10) begin
      next_phi2();
      total++;
      if (pb_out[6] != prev) begin
        toggles++;
        prev = pb_out[6];
      end
      fell = !irq_n;
    end
    assert (fell) else begin
      $display("Timer B interrupt never arrived while counting A underflows");
      event_errors++;
    end
    expect_eq("pb6 toggles", 8'(nb_chain + 1), 8'(toggles));
    read_reg(reg_icr, rd);
    expect_eq("icr", icr_ref(5'b00011, 1'b1), rd);
    write_reg(reg_cra, 8'h00);
    write_reg(reg_crb, 8'h00);
    finish_test("timer B chained");
  endtask

  task automatic mask_and_flag();
    logic [7:0] rd;
    err_start = errors + event_errors;
    @(posedge clk);
    mode <= 1'b1;
    write_reg(reg_icr, 8'h1f);
    write_reg(reg_ta_lo, 8'(la_mask));
    write_reg(reg_ta_hi, 8'(la_mask >> 8));
    write_reg(reg_cra, 8'h09);
    repeat (la_mask + 4) next_phi2();
    expect_eq("irq_n", 8'h01, 8'(irq_n));
    read_reg(reg_icr, rd);
    expect_eq("icr", icr_ref(5'b00001, 1'b0), rd);
    @(posedge clk);
    flag_n <= 1'b0;
    next_phi2();
    next_phi2();
    expect_eq("irq_n", 8'h01, 8'(irq_n));
    write_reg(reg_icr, 8'h90);
    next_phi2();
    next_phi2();
    expect_eq("irq_n", 8'h00, 8'(irq_n));
    read_reg(reg_icr, rd);
    expect_eq("icr", icr_ref(5'b10000, 1'b1), rd);
    @(posedge clk);
    flag_n <= 1'b1;
    next_phi2();
    next_phi2();
    expect_eq("irq_n", 8'h01, 8'(irq_n));
    finish_test("masking and FLAG");
  endtask

  initial begin
    int_reset <= 1'b1;
    mode      <= 1'b0;
    cs_n      <= 1'b1;
    rw        <= 1'b1;
    rs        <= 4'h0;
    db_in     <= 8'h00;
    pa_in     <= 8'h5a;
    pb_in     <= 8'ha5;
    flag_n    <= 1'b1;
    cnt_in    <= 1'b0;
    lcg_state = 32'he869;
    repeat (3) @(posedge clk);
    int_reset <= 1'b0;
    check_ports();
    oneshot_irq();
    continuous_pb6();
    chained_tb();
    mask_and_flag();
    $display("%0d checks, %0d errors", checks, errors + event_errors);
    if (errors + event_errors == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// ==== sources.f ====
logic/cia_regmap_pkg.sv
logic/cia_timer_pkg.sv
logic/cia_reg_bus_if.sv
logic/cia_bus_decode.sv
logic/cia_ports.sv
logic/cia_timers.sv
logic/cia_irq.sv
logic/cia_top.sv
sim/cia_tb.sv
